// File: hdl/rv_isa_pkg.sv
package rv_isa_pkg;

	localparam int NUM_REGS = 32;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [4:0]  shamt_t;

	// Major opcodes of the supported subset
	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;

	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SRL  = 3'b101;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;

	// SUB is the only alternate funct7 kept
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_PASS_B
	} alu_op_e;

endpackage

// File: hdl/pipe_pkg.sv
package pipe_pkg;
	import rv_isa_pkg::*;

	// Source of ALU operand B
	typedef enum logic [1:0] {
		B_REG,
		B_IMM,
		B_SHAMT
	} b_sel_e;

	// Decode register contents
	typedef struct packed {
		logic      valid;
		word_t     pc;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		logic      we;
		alu_op_e   alu_op;
		b_sel_e    b_sel;
		word_t     imm;
		shamt_t    shamt;
		logic      is_branch;
		logic      br_ne;
		word_t     b_imm;
	} dec_t;

	// Issue register, operands already resolved
	typedef struct packed {
		logic      valid;
		word_t     pc;
		reg_addr_t rd;
		logic      we;
		alu_op_e   alu_op;
		word_t     op_a;
		word_t     op_b;
		logic      is_branch;
		logic      br_ne;
		word_t     b_imm;
	} iss_t;

	typedef struct packed {
		logic      valid;
		word_t     pc;
		reg_addr_t rd;
		logic      we;
		word_t     data;
	} res_t;

endpackage

// File: hdl/regfile.sv
module regfile
	import rv_isa_pkg::*;
(
	input  logic      clk,
	input  logic      nrst,
	input  logic      wr_en,
	input  reg_addr_t wr_addr,
	input  word_t     wr_data,
	input  reg_addr_t rs1,
	input  reg_addr_t rs2,
	output word_t     rd1,
	output word_t     rd2
);

	word_t regs [NUM_REGS];

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			regs <= '{default: '0};
		else if (wr_en && wr_addr != '0)
			regs[wr_addr] <= wr_data;
	end

	// Same-cycle write is visible to the reader
	assign rd1 = (rs1 == '0) ? '0 : (wr_en && wr_addr == rs1) ? wr_data : regs[rs1];
	assign rd2 = (rs2 == '0) ? '0 : (wr_en && wr_addr == rs2) ? wr_data : regs[rs2];

endmodule

// File: hdl/hazard_scoreboard.sv
module hazard_scoreboard
	import rv_isa_pkg::*, pipe_pkg::*;
(
	input  logic      clk,
	input  logic      nrst,
	input  dec_t      dec,
	input  logic      issue_load,
	input  logic      wr_en,
	input  reg_addr_t wr_addr,
	output logic      stall
);

	// Writes in flight per register, issue and result can both hold one
	logic [1:0]          pend_cnt [NUM_REGS];
	logic [NUM_REGS-1:0] set_vec;
	logic [NUM_REGS-1:0] clr_vec;
	logic [1:0]          rs1_left;
	logic [1:0]          rs2_left;

	always_comb
	begin
		set_vec = '0;
		clr_vec = '0;
		if (issue_load && dec.we)
			set_vec[dec.rd] = 1'b1;
		if (wr_en)
			clr_vec[wr_addr] = 1'b1;
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			pend_cnt <= '{default: '0};
		else
		begin
			for (int r = 0; r < NUM_REGS; r++)
			begin
				if (set_vec[r] && !clr_vec[r])
					pend_cnt[r] <= pend_cnt[r] + 2'd1;
				else if (clr_vec[r] && !set_vec[r])
					pend_cnt[r] <= pend_cnt[r] - 2'd1;
			end
		end
	end

	// The write landing this cycle no longer blocks
	assign rs1_left = pend_cnt[dec.rs1] - {1'b0, clr_vec[dec.rs1]};
	assign rs2_left = pend_cnt[dec.rs2] - {1'b0, clr_vec[dec.rs2]};

	// LUI has no rs1, only B_REG reads rs2
	assign stall = dec.valid &&
		((dec.alu_op != ALU_PASS_B && rs1_left != 2'd0) ||
		(dec.b_sel == B_REG && rs2_left != 2'd0));

endmodule

// File: hdl/decode_stage.sv
module decode_stage
	import rv_isa_pkg::*, pipe_pkg::*;
(
	input  logic  clk,
	input  logic  nrst,
	input  logic  instr_valid,
	input  word_t instr,
	input  word_t instr_pc,
	input  logic  stall,
	input  logic  kill,
	output dec_t  dec
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       known;
	dec_t       dec_next;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	// Shared funct3 map for register and immediate forms
	function automatic alu_op_e f3_alu_op(input logic [2:0] f3);
		case (f3)
			F3_SLL:  return ALU_SLL;
			F3_SLT:  return ALU_SLT;
			F3_XOR:  return ALU_XOR;
			F3_SRL:  return ALU_SRL;
			F3_OR:   return ALU_OR;
			F3_AND:  return ALU_AND;
			default: return ALU_ADD;
		endcase
	endfunction

	always_comb
	begin
		dec_next        = '0;
		dec_next.pc     = instr_pc;
		dec_next.rs1    = instr[19:15];
		dec_next.rs2    = instr[24:20];
		dec_next.rd     = instr[11:7];
		dec_next.shamt  = instr[24:20];
		dec_next.imm    = {{20{instr[31]}}, instr[31:20]};
		dec_next.b_imm  = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
			instr[11:8], 1'b0};
		dec_next.alu_op = f3_alu_op(funct3);
		dec_next.b_sel  = B_REG;
		known           = 1'b0;

		case (opcode)
			OP_REG:
			begin
				dec_next.we = 1'b1;
				if (funct3 == F3_ADD && funct7 == F7_ALT)
					dec_next.alu_op = ALU_SUB;
				known = funct3 != F3_SLTU &&
					(funct7 == F7_BASE || (funct7 == F7_ALT && funct3 == F3_ADD));
			end
			OP_IMM:
			begin
				dec_next.we = 1'b1;
				if (funct3 == F3_SLL || funct3 == F3_SRL)
				begin
					dec_next.b_sel = B_SHAMT;
					known          = funct7 == F7_BASE;
				end
				else
				begin
					dec_next.b_sel = B_IMM;
					known          = funct3 != F3_SLTU;
				end
			end
			OP_LUI:
			begin
				dec_next.we     = 1'b1;
				dec_next.alu_op = ALU_PASS_B;
				dec_next.b_sel  = B_IMM;
				dec_next.imm    = {instr[31:12], 12'b0};
				known           = 1'b1;
			end
			OP_BRANCH:
			begin
				// Branches retire with rd 0
				dec_next.rd        = '0;
				dec_next.is_branch = 1'b1;
				dec_next.br_ne     = funct3 == F3_BNE;
				known              = funct3 == F3_BEQ || funct3 == F3_BNE;
			end
			default:
				known = 1'b0;
		endcase

		if (dec_next.rd == '0 || !known)
			dec_next.we = 1'b0;
		dec_next.valid = instr_valid && known;
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			dec <= '0;
		else if (kill)
		begin
			dec.valid <= 1'b0;
			dec.we    <= 1'b0;
		end
		else if (!stall)
			dec <= dec_next;
	end

endmodule

// File: hdl/issue_stage.sv
module issue_stage
	import rv_isa_pkg::*, pipe_pkg::*;
(
	input  logic      clk,
	input  logic      nrst,
	input  dec_t      dec,
	input  logic      kill,
	input  logic      wr_en,
	input  reg_addr_t wr_addr,
	input  word_t     wr_data,
	output logic      stall,
	output iss_t      iss
);

	word_t rd1;
	word_t rd2;
	word_t op_b;
	logic  issue_load;

	// A real instruction moves on only without stall or kill
	assign issue_load = dec.valid && !stall && !kill;

	regfile u_regfile (
		.clk     (clk),
		.nrst    (nrst),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rs1     (dec.rs1),
		.rs2     (dec.rs2),
		.rd1     (rd1),
		.rd2     (rd2)
	);

	hazard_scoreboard u_scoreboard (
		.clk        (clk),
		.nrst       (nrst),
		.dec        (dec),
		.issue_load (issue_load),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.stall      (stall)
	);

	always_comb
	begin
		case (dec.b_sel)
			B_IMM:   op_b = dec.imm;
			B_SHAMT: op_b = {27'b0, dec.shamt};
			default: op_b = rd2;
		endcase
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			iss <= '0;
		else
		begin
			// Bubble keeps valid and we low
			iss.valid     <= issue_load;
			iss.we        <= issue_load && dec.we;
			iss.pc        <= dec.pc;
			iss.rd        <= dec.rd;
			iss.alu_op    <= dec.alu_op;
			iss.op_a      <= rd1;
			iss.op_b      <= op_b;
			iss.is_branch <= dec.is_branch;
			iss.br_ne     <= dec.br_ne;
			iss.b_imm     <= dec.b_imm;
		end
	end

endmodule

// File: hdl/execute_stage.sv
module execute_stage
	import rv_isa_pkg::*, pipe_pkg::*;
(
	input  logic  clk,
	input  logic  nrst,
	input  iss_t  iss,
	output logic  kill,
	output word_t redirect_pc,
	output res_t  res
);

	word_t alu_y;
	logic  ops_equal;

	always_comb
	begin
		case (iss.alu_op)
			ALU_ADD:    alu_y = iss.op_a + iss.op_b;
			ALU_SUB:    alu_y = iss.op_a - iss.op_b;
			ALU_AND:    alu_y = iss.op_a & iss.op_b;
			ALU_OR:     alu_y = iss.op_a | iss.op_b;
			ALU_XOR:    alu_y = iss.op_a ^ iss.op_b;
			ALU_SLT:    alu_y = {31'b0, $signed(iss.op_a) < $signed(iss.op_b)};
			ALU_SLL:    alu_y = iss.op_a << iss.op_b[4:0];
			ALU_SRL:    alu_y = iss.op_a >> iss.op_b[4:0];
			ALU_PASS_B: alu_y = iss.op_b;
			default:    alu_y = '0;
		endcase
	end

	assign ops_equal = iss.op_a == iss.op_b;

	// Taken branch squashes decode and the incoming issue entry
	assign kill        = iss.valid && iss.is_branch && (iss.br_ne ? !ops_equal : ops_equal);
	assign redirect_pc = iss.pc + iss.b_imm;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			res <= '0;
		else
		begin
			res.valid <= iss.valid;
			res.pc    <= iss.pc;
			res.rd    <= iss.rd;
			res.we    <= iss.we;
			// Branches and x0 writes carry no data
			res.data  <= iss.we ? alu_y : '0;
		end
	end

endmodule

// File: hdl/result_stage.sv
module result_stage
	import rv_isa_pkg::*, pipe_pkg::*;
(
	input  logic      clk,
	input  logic      nrst,
	input  res_t      res,
	output logic      wr_en,
	output reg_addr_t wr_addr,
	output word_t     wr_data,
	output logic      commit_valid,
	output word_t     commit_pc,
	output reg_addr_t commit_rd,
	output word_t     commit_data
);

	// Write back lands at the end of this cycle
	assign wr_en   = res.valid && res.we;
	assign wr_addr = res.rd;
	assign wr_data = res.data;

	// Every valid entry retires, writing or not
	assign commit_valid = res.valid;
	assign commit_pc    = res.pc;
	assign commit_rd    = res.rd;
	assign commit_data  = res.data;

endmodule

// File: hdl/pipe_slice_top.sv
module pipe_slice_top
	import rv_isa_pkg::*, pipe_pkg::*;
(
	input  logic      clk,
	input  logic      nrst,
	input  logic      instr_valid,
	input  word_t     instr,
	input  word_t     instr_pc,
	output logic      instr_ready,
	output logic      redirect_valid,
	output word_t     redirect_pc,
	output logic      commit_valid,
	output word_t     commit_pc,
	output reg_addr_t commit_rd,
	output word_t     commit_data
);

	dec_t      dec;
	iss_t      iss;
	res_t      res;
	logic      stall;
	logic      kill;
	logic      wr_en;
	reg_addr_t wr_addr;
	word_t     wr_data;

	assign instr_ready    = !(stall || kill);
	assign redirect_valid = kill;

	decode_stage u_decode (
		.clk         (clk),
		.nrst        (nrst),
		.instr_valid (instr_valid),
		.instr       (instr),
		.instr_pc    (instr_pc),
		.stall       (stall),
		.kill        (kill),
		.dec         (dec)
	);

	issue_stage u_issue (
		.clk     (clk),
		.nrst    (nrst),
		.dec     (dec),
		.kill    (kill),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.stall   (stall),
		.iss     (iss)
	);

	execute_stage u_execute (
		.clk         (clk),
		.nrst        (nrst),
		.iss         (iss),
		.kill        (kill),
		.redirect_pc (redirect_pc),
		.res         (res)
	);

	result_stage u_result (
		.clk          (clk),
		.nrst         (nrst),
		.res          (res),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.commit_valid (commit_valid),
		.commit_pc    (commit_pc),
		.commit_rd    (commit_rd),
		.commit_data  (commit_data)
	);

endmodule

// File: verif/pipe_slice_sva.sv
module pipe_slice_sva
	import rv_isa_pkg::*;
(
	input logic      clk,
	input logic      nrst,
	input logic      redirect_valid,
	input logic      dec_valid,
	input logic      commit_valid,
	input reg_addr_t commit_rd,
	input word_t     commit_data
);

	timeunit 1ns;
	timeprecision 1ps;

	// Read by the testbench to end the run
	int fail_count = 0;

	// Branches and x0 writes retire without data
	commit_x0_zero: assert property (@(posedge clk) disable iff (!nrst)
		commit_valid && commit_rd == '0 |-> commit_data == '0)
	else
	begin
		$error("commit to x0 carries data %h", commit_data);
		fail_count++;
	end

	// No fetch is taken while the pipe redirects
	redirect_squashes_decode: assert property (@(posedge clk) disable iff (!nrst)
		redirect_valid |=> !dec_valid)
	else
	begin
		$error("decode entry still valid after a redirect");
		fail_count++;
	end

	// Pipe is still empty right after reset
	quiet_after_reset: assert property (@(posedge clk)
		$rose(nrst) |-> !commit_valid ##1 !commit_valid)
	else
	begin
		$error("commit_valid seen right after reset release");
		fail_count++;
	end

endmodule

bind pipe_slice_top pipe_slice_sva u_sva (
	.clk            (clk),
	.nrst           (nrst),
	.redirect_valid (redirect_valid),
	.dec_valid      (dec.valid),
	.commit_valid   (commit_valid),
	.commit_rd      (commit_rd),
	.commit_data    (commit_data)
);

// File: verif/pipe_slice_tb.sv
module pipe_slice_tb
	import rv_isa_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int PROG_WORDS     = 64;
	localparam int COMMIT_TIMEOUT = 100;
	localparam int DRAIN_CYCLES   = 10;

	typedef struct packed {
		word_t     pc;
		reg_addr_t rd;
		word_t     data;
	} commit_t;

	logic      clk;
	logic      nrst;
	logic      instr_valid;
	word_t     instr;
	word_t     instr_pc;
	logic      instr_ready;
	logic      redirect_valid;
	word_t     redirect_pc;
	logic      commit_valid;
	word_t     commit_pc;
	reg_addr_t commit_rd;
	word_t     commit_data;

	word_t   prog_mem [PROG_WORDS];
	logic    prog_loaded [PROG_WORDS];
	commit_t exp_q [$];
	word_t   fetch_pc;
	logic    accepted;
	int      commit_count;

	pipe_slice_top dut0 (
		.clk            (clk),
		.nrst           (nrst),
		.instr_valid    (instr_valid),
		.instr          (instr),
		.instr_pc       (instr_pc),
		.instr_ready    (instr_ready),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.commit_valid   (commit_valid),
		.commit_pc      (commit_pc),
		.commit_rd      (commit_rd),
		.commit_data    (commit_data)
	);

	always #20 clk = ~clk;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("** FAIL **");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_equal(input word_t got, input word_t exp, input string what);
		if (got !== exp)
		begin
			abort_run($sformatf("FAIL %0t: %s is %h, expected %h", $time, what, got, exp));
		end
	endtask

	task automatic load_trace();
		int      fd;
		int      n;
		string   line;
		word_t   a;
		word_t   b;
		word_t   c;
		commit_t rec;
		fd = $fopen("verif/pipe_slice_trace.txt", "r");
		if (fd == 0)
			abort_run("Cannot open the trace file verif/pipe_slice_trace.txt");
		else
		begin
			while (!$feof(fd))
			begin
				n = $fgets(line, fd);
				if (n > 0)
				begin
					if ($sscanf(line, "I %h %h", a, b) == 2)
					begin
						prog_mem[a[7:2]]    = b;
						prog_loaded[a[7:2]] = 1'b1;
					end
					else if ($sscanf(line, "C %h %h %h", a, b, c) == 3)
					begin
						rec.pc   = a;
						rec.rd   = b[4:0];
						rec.data = c;
						exp_q.push_back(rec);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// Only loaded program words are valid fetches
	task automatic drive_fetch(input word_t pc);
		instr_pc = pc;
		if (pc[31:8] == '0 && prog_loaded[pc[7:2]])
		begin
			instr_valid = 1'b1;
			instr       = prog_mem[pc[7:2]];
		end
		else
		begin
			instr_valid = 1'b0;
			instr       = '0;
		end
	endtask

	task automatic check_commit();
		commit_t rec;
		if (exp_q.size() == 0)
			abort_run($sformatf("Unexpected commit from pc %h after the last expected one",
				commit_pc));
		else
		begin
			rec = exp_q.pop_front();
			commit_count++;
			check_equal(commit_pc, rec.pc, "commit pc");
			check_equal(word_t'(commit_rd), word_t'(rec.rd),
				$sformatf("commit rd at pc %h", rec.pc));
			check_equal(commit_data, rec.data, $sformatf("commit data at pc %h", rec.pc));
		end
	endtask

	// Handshake seen at the rising edge
	always @(posedge clk)
		accepted <= nrst && instr_valid && instr_ready;

	// Redirect wins over the next sequential pc
	always @(negedge clk)
	begin
		if (redirect_valid)
			fetch_pc = redirect_pc;
		else if (accepted)
			fetch_pc = fetch_pc + 32'd4;
		drive_fetch(fetch_pc);
	end

	always @(negedge clk)
	begin
		if (dut0.u_sva.fail_count != 0)
			abort_run("A bound assertion on the DUT failed");
		else if (nrst && commit_valid)
			check_commit();
	end

	initial
	begin
		int idle_cycles;
		int last_count;
		clk          = 1'b0;
		nrst         = 1'b0;
		instr_valid  = 1'b0;
		instr        = '0;
		instr_pc     = '0;
		fetch_pc     = '0;
		accepted     = 1'b0;
		commit_count = 0;
		for (int i = 0; i < PROG_WORDS; i++)
			prog_loaded[i] = 1'b0;
		load_trace();
		if (exp_q.size() == 0)
			abort_run("The trace file holds no commit records");

		repeat (2) @(posedge clk);
		@(negedge clk);
		nrst = 1'b1;

		// Idle count restarts with every commit
		idle_cycles = 0;
		last_count  = commit_count;
		while (exp_q.size() != 0 && idle_cycles < COMMIT_TIMEOUT)
		begin
			@(posedge clk);
			if (commit_count != last_count)
			begin
				last_count  = commit_count;
				idle_cycles = 0;
			end
			else
				idle_cycles++;
		end

		if (exp_q.size() != 0)
			abort_run($sformatf("Commits stopped arriving with %0d still expected",
				exp_q.size()));
		else
		begin
			// Stray commits behind the last one show up here
			for (int i = 0; i < DRAIN_CYCLES; i++)
				@(negedge clk);
			if (dut0.u_sva.fail_count == 0)
			begin
				$display("** PASS **");
				$finish;
			end
			else
				abort_run("A bound assertion on the DUT failed");
		end
	end

endmodule

// File: pipe_slice.f
hdl/rv_isa_pkg.sv
hdl/pipe_pkg.sv
hdl/regfile.sv
hdl/hazard_scoreboard.sv
hdl/decode_stage.sv
hdl/issue_stage.sv
hdl/execute_stage.sv
hdl/result_stage.sv
hdl/pipe_slice_top.sv
verif/pipe_slice_sva.sv
verif/pipe_slice_tb.sv

// File: verif/pipe_slice_trace.txt
# I <pc> <instruction word>
# C <pc> <rd> <data>  expected commits in program order
I 00 06400093
I 04 ff900113
I 08 123451b7
I 0c 00208233
I 10 402082b3
I 14 00112333
I 18 0020a3b3
I 1c 0020c433
I 20 0030e4b3
I 24 00317533
I 28 00409593
I 2c 01c15613
I 30 0061d6b3
I 34 00409733
I 38 ffa12793
# dependent chain on x19 and x20
I 3c 00500993
I 40 00398993
I 44 00299993
I 48 40198a33
I 4c 014a0a33
# x0 write, then x0 read
I 50 00508013
I 54 00100ab3
# taken beq to 64, taken bne to 78
I 58 00108663
I 5c 00100b13
I 60 00200b13
I 64 05500b93
I 68 001b9863
I 6c 00300c13
I 70 00400c13
I 74 00500c13
# not taken branches, unknown word at 80
I 78 00208463
I 7c 01509463
I 80 ffffffff
I 84 007c0c93
I 88 017c8d33
C 00 01 00000064
C 04 02 fffffff9
C 08 03 12345000
C 0c 04 0000005d
C 10 05 0000006b
C 14 06 00000001
C 18 07 00000000
C 1c 08 ffffff9d
C 20 09 12345064
C 24 0a 12345000
C 28 0b 00000640
C 2c 0c 0000000f
C 30 0d 091a2800
C 34 0e 80000000
C 38 0f 00000001
C 3c 13 00000005
C 40 13 00000008
C 44 13 00000020
C 48 14 ffffffbc
C 4c 14 ffffff78
C 50 00 00000000
C 54 15 00000064
C 58 00 00000000
C 64 17 00000055
C 68 00 00000000
C 78 00 00000000
C 7c 00 00000000
C 84 19 00000007
C 88 1a 0000005c
